/* sim.f */
exu_pkg.sv
exu_alu.sv
exu_bju.sv
exu_commit.sv
exu_top.sv
tb_exu.sv

/* run_sim.sh */
#!/bin/bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_exu -o tb_exu \
  && ./obj_dir/tb_exu > sim.log 2>&1 \
  || { echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_exu.sv */
`timescale 1ns/1ns

module tb_exu import exu_pkg::*; ();

  localparam int NUM_INSTR  = 400;
  localparam int MAX_CYCLES = 5 * NUM_INSTR;

  // expected output items in order of acceptance
  typedef struct packed {
    op_class_e              cls;
    logic                   rd_wr_en;
    logic [REG_IDX_W-1:0]   rd_idx;
    logic [XLEN-1:0]        result;
    logic                   jump;
    logic [XLEN-1:0]        jump_addr;
    logic                   ls_load;
    logic                   ls_store;
    ls_size_e               ls_size;
    logic                   ls_unsigned;
    logic [XLEN-1:0]        store_data;
  } exp_t;

  logic clk, arst_n_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  op_class_e op_class_i;
  alu_op_e alu_op_i;
  bjp_op_e bjp_op_i;
  ls_size_e ls_size_i, ls_size_o;
  logic word_op_i, ls_load_i, ls_store_i, ls_unsigned_i, rd_wr_en_i;
  logic rd_wr_en_o, jump_o, ls_load_o, ls_store_o, ls_unsigned_o;
  logic [REG_IDX_W-1:0] rd_idx_i, rd_idx_o;
  logic [XLEN-1:0] op1_i, op2_i, jp_base_i, jp_offset_i;
  logic [XLEN-1:0] result_o, jump_addr_o, store_data_o;
  logic [203:0] out_bus;

  integer seed;
  int mism_cnt = 0;
  int prot_cnt = 0;
  int reset_errs = 0;
  int n_checked = 0;
  int cycles = 0;
  exp_t exp_q[$];
  exp_t head;

  exu_top dut0 (.*);

  assign out_bus = {rd_wr_en_o, rd_idx_o, result_o, jump_o, jump_addr_o, ls_load_o,
                    ls_store_o, ls_size_o, ls_unsigned_o, store_data_o};

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // expected fields for the instruction now on the inputs
  function automatic exp_t model();
    exp_t        e;
    logic [31:0] w;
    logic [5:0]  sh;
    logic        taken;
    sh = op2_i[5:0];
    e.cls = op_class_i;
    case (alu_op_i)
      ALU_ADD:  e.result = op1_i + op2_i;
      ALU_SUB:  e.result = op1_i - op2_i;
      ALU_SLL:  e.result = op1_i << sh;
      ALU_SRL:  e.result = op1_i >> sh;
      ALU_SRA:  e.result = $signed(op1_i) >>> sh;
      ALU_SLT:  e.result = {63'b0, $signed(op1_i) < $signed(op2_i)};
      ALU_SLTU: e.result = {63'b0, op1_i < op2_i};
      ALU_XOR:  e.result = op1_i ^ op2_i;
      ALU_OR:   e.result = op1_i | op2_i;
      ALU_AND:  e.result = op1_i & op2_i;
      ALU_LUI:  e.result = op2_i;
      ALU_MUL:  e.result = op1_i * op2_i;
      default:  e.result = '0;
    endcase
    if (word_op_i && (alu_op_i inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA})) begin
      case (alu_op_i)
        ALU_ADD: w = op1_i[31:0] + op2_i[31:0];
        ALU_SUB: w = op1_i[31:0] - op2_i[31:0];
        ALU_SLL: w = op1_i[31:0] << sh[4:0];
        ALU_SRL: w = op1_i[31:0] >> sh[4:0];
        default: w = $signed(op1_i[31:0]) >>> sh[4:0];
      endcase
      e.result = {{32{w[31]}}, w};
    end
    case (bjp_op_i)
      BJP_BEQ:  taken = (op1_i == op2_i);
      BJP_BNE:  taken = (op1_i != op2_i);
      BJP_BLT:  taken = ($signed(op1_i) < $signed(op2_i));
      BJP_BGE:  taken = ($signed(op1_i) >= $signed(op2_i));
      BJP_BLTU: taken = (op1_i < op2_i);
      BJP_BGEU: taken = (op1_i >= op2_i);
      default:  taken = 1'b1;
    endcase
    e.jump        = taken && (op_class_i == CLS_BJP);
    e.jump_addr   = jp_base_i + jp_offset_i;
    if (bjp_op_i == BJP_JALR) e.jump_addr[0] = 1'b0;
    e.ls_load     = ls_load_i && (op_class_i == CLS_LS);
    e.ls_store    = ls_store_i && (op_class_i == CLS_LS);
    e.ls_size     = ls_size_i;
    e.ls_unsigned = ls_unsigned_i;
    e.store_data  = jp_offset_i;
    e.rd_wr_en    = rd_wr_en_i;
    e.rd_idx      = rd_idx_i;
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      mism_cnt++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_item(input exp_t e);
    compare_field("rd_wr_en_o", {63'b0, rd_wr_en_o}, {63'b0, e.rd_wr_en});
    compare_field("rd_idx_o", {59'b0, rd_idx_o}, {59'b0, e.rd_idx});
    compare_field("result_o", result_o, e.result);
    compare_field("jump_o", {63'b0, jump_o}, {63'b0, e.jump});
    compare_field("ls_load_o", {63'b0, ls_load_o}, {63'b0, e.ls_load});
    compare_field("ls_store_o", {63'b0, ls_store_o}, {63'b0, e.ls_store});
    if (e.cls == CLS_BJP) compare_field("jump_addr_o", jump_addr_o, e.jump_addr);
    if (e.cls == CLS_LS) begin
      compare_field("ls_size_o", {62'b0, ls_size_o}, {62'b0, e.ls_size});
      compare_field("ls_unsigned_o", {63'b0, ls_unsigned_o}, {63'b0, e.ls_unsigned});
      compare_field("store_data_o", store_data_o, e.store_data);
    end
  endtask

  // corner values show up in about half of the draws
  task automatic draw_operand(output logic [XLEN-1:0] v);
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    v = '0;
      3'd1:    v = '1;
      3'd2:    v = 64'h8000_0000_0000_0000;
      3'd3:    v = (r[4:3] == 2'd0) ? 64'd31 : (r[4] ? 64'd63 : 64'd32);
      default: v = {$random(seed), $random(seed)};
    endcase
  endtask

  task automatic draw_instr();
    logic [31:0] r;
    r = $random(seed);
    op_class_i    = (r[3:0] < 4'd8) ? CLS_ALU : ((r[3:0] < 4'd12) ? CLS_BJP : CLS_LS);
    alu_op_i      = alu_op_e'(r[7:4] % 4'd12);
    word_op_i     = r[8];
    bjp_op_i      = bjp_op_e'(r[11:9]);
    ls_load_i     = r[12];
    ls_store_i    = ~r[12];
    ls_size_i     = ls_size_e'(r[14:13]);
    ls_unsigned_i = r[15];
    rd_wr_en_i    = r[16];
    rd_idx_i      = r[21:17];
    draw_operand(op1_i);
    draw_operand(op2_i);
    draw_operand(jp_base_i);
    draw_operand(jp_offset_i);
    // address and link value both come from a plain add
    if (op_class_i != CLS_ALU) begin
      alu_op_i  = ALU_ADD;
      word_op_i = 1'b0;
    end
    if (op_class_i == CLS_BJP && (bjp_op_i inside {BJP_JAL, BJP_JALR})) op2_i = 64'd4;
    else if (op_class_i == CLS_BJP && r[22]) op2_i = op1_i;
  endtask

  // pop on each output transfer and push on each accept
  always @(posedge clk) begin
    if (arst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          prot_cnt++;
          $display("output transfer at %0t ns with no instruction outstanding", $time);
        end else begin
          head = exp_q.pop_front();
          check_item(head);
          n_checked++;
        end
      end
      if (in_valid_i && in_ready_o) exp_q.push_back(model());
    end
  end

  hold_chk: assert property (@(posedge clk) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_bus)))
    else begin
      prot_cnt++;
      $display("outputs changed under back-pressure at %0t ns", $time);
    end

  stall_chk: assert property (@(posedge clk) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |-> !in_ready_o)
    else begin
      prot_cnt++;
      $display("in_ready_o stayed high under back-pressure at %0t ns", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d items checked", cycles, n_checked);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    logic        took;
    logic [31:0] r;
    int          n_sent;
    seed = 99;
    n_sent = 0;
    arst_n_i = 1'b0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    op_class_i = CLS_ALU;
    alu_op_i = ALU_ADD;
    word_op_i = 1'b0;
    bjp_op_i = BJP_JAL;
    ls_load_i = 1'b0;
    ls_store_i = 1'b0;
    ls_size_i = LS_BYTE;
    ls_unsigned_i = 1'b0;
    rd_wr_en_i = 1'b0;
    rd_idx_i = '0;
    op1_i = '0;
    op2_i = '0;
    jp_base_i = '0;
    jp_offset_i = '0;
    repeat (4) @(posedge clk);
    #2;
    arst_n_i = 1'b1;
    assert ({out_valid_o, jump_o, ls_load_o, ls_store_o, rd_wr_en_o} == 5'b0) else begin
      reset_errs++;
      $display("Mismatch at %0t ns: reset flags got %b expected 00000", $time,
               {out_valid_o, jump_o, ls_load_o, ls_store_o, rd_wr_en_o});
    end
    draw_instr();
    in_valid_i = 1'b1;
    while (n_sent < NUM_INSTR) begin
      @(posedge clk);
      took = in_valid_i && in_ready_o;
      if (took) n_sent++;
      #2;
      r = $random(seed);
      out_ready_i = (r[1:0] != 2'b00);
      if (took || !in_valid_i) begin
        draw_instr();
        in_valid_i = (r[4:2] != 3'b000) && (n_sent < NUM_INSTR);
      end
    end
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    while (out_valid_o) begin
      @(posedge clk);
      #2;
    end
    if (n_checked != NUM_INSTR) begin
      $display("expected %0d output items but only %0d came out", NUM_INSTR, n_checked);
    end
    $display("errors: %0d mismatch, %0d protocol, %0d reset; %0d items checked",
             mism_cnt, prot_cnt, reset_errs, n_checked);
    if (mism_cnt == 0 && prot_cnt == 0 && reset_errs == 0 && n_checked == NUM_INSTR) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* exu_top.sv */
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  op_class_e            op_class_i,
  input  alu_op_e              alu_op_i,
  input  logic                 word_op_i,
  input  bjp_op_e              bjp_op_i,
  input  logic                 ls_load_i,
  input  logic                 ls_store_i,
  input  ls_size_e             ls_size_i,
  input  logic                 ls_unsigned_i,
  input  logic                 rd_wr_en_i,
  input  logic [REG_IDX_W-1:0] rd_idx_i,
  input  logic [XLEN-1:0]      op1_i,
  input  logic [XLEN-1:0]      op2_i,
  input  logic [XLEN-1:0]      jp_base_i,
  input  logic [XLEN-1:0]      jp_offset_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 rd_wr_en_o,
  output logic [REG_IDX_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]      result_o,
  output logic                 jump_o,
  output logic [XLEN-1:0]      jump_addr_o,
  output logic                 ls_load_o,
  output logic                 ls_store_o,
  output ls_size_e             ls_size_o,
  output logic                 ls_unsigned_o,
  output logic [XLEN-1:0]      store_data_o
);

  logic [XLEN-1:0] alu_res;
  logic            bjp_taken;
  logic [XLEN-1:0] bjp_target;

  exu_alu u_alu (
    .alu_op_i  (alu_op_i),
    .word_op_i (word_op_i),
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .alu_res_o (alu_res)
  );

  // branch compare reuses the datapath operands
  exu_bju u_bju (
    .bjp_op_i    (bjp_op_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .jp_base_i   (jp_base_i),
    .jp_offset_i (jp_offset_i),
    .taken_o     (bjp_taken),
    .target_o    (bjp_target)
  );

  // store data shares the jump offset operand
  exu_commit u_commit (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .op_class_i    (op_class_i),
    .rd_wr_en_i    (rd_wr_en_i),
    .rd_idx_i      (rd_idx_i),
    .alu_res_i     (alu_res),
    .bjp_taken_i   (bjp_taken),
    .bjp_target_i  (bjp_target),
    .ls_load_i     (ls_load_i),
    .ls_store_i    (ls_store_i),
    .ls_size_i     (ls_size_i),
    .ls_unsigned_i (ls_unsigned_i),
    .store_data_i  (jp_offset_i),
    .rd_wr_en_o    (rd_wr_en_o),
    .rd_idx_o      (rd_idx_o),
    .result_o      (result_o),
    .jump_o        (jump_o),
    .jump_addr_o   (jump_addr_o),
    .ls_load_o     (ls_load_o),
    .ls_store_o    (ls_store_o),
    .ls_size_o     (ls_size_o),
    .ls_unsigned_o (ls_unsigned_o),
    .store_data_o  (store_data_o)
  );

endmodule

/* exu_commit.sv */
`timescale 1ns/1ns

module exu_commit import exu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  input  op_class_e            op_class_i,
  input  logic                 rd_wr_en_i,
  input  logic [REG_IDX_W-1:0] rd_idx_i,
  input  logic [XLEN-1:0]      alu_res_i,
  input  logic                 bjp_taken_i,
  input  logic [XLEN-1:0]      bjp_target_i,
  input  logic                 ls_load_i,
  input  logic                 ls_store_i,
  input  ls_size_e             ls_size_i,
  input  logic                 ls_unsigned_i,
  input  logic [XLEN-1:0]      store_data_i,
  output logic                 rd_wr_en_o,
  output logic [REG_IDX_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]      result_o,
  output logic                 jump_o,
  output logic [XLEN-1:0]      jump_addr_o,
  output logic                 ls_load_o,
  output logic                 ls_store_o,
  output ls_size_e             ls_size_o,
  output logic                 ls_unsigned_o,
  output logic [XLEN-1:0]      store_data_o
);

  logic accept;
  logic is_bjp;
  logic is_ls;

  // room when empty or when the current item leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  assign is_bjp = (op_class_i == CLS_BJP);
  assign is_ls  = (op_class_i == CLS_LS);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      // drained with nothing new behind it
      out_valid_o <= 1'b0;
    end
  end

  // control flags gated by instruction class
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_wr_en_o <= 1'b0;
      jump_o     <= 1'b0;
      ls_load_o  <= 1'b0;
      ls_store_o <= 1'b0;
    end else if (accept) begin
      rd_wr_en_o <= rd_wr_en_i;
      jump_o     <= is_bjp & bjp_taken_i;
      ls_load_o  <= is_ls & ls_load_i;
      ls_store_o <= is_ls & ls_store_i;
    end
  end

  // payload follows the flags above
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_idx_o      <= rd_idx_i;
      result_o      <= alu_res_i;
      jump_addr_o   <= bjp_target_i;
      ls_size_o     <= ls_size_i;
      ls_unsigned_o <= ls_unsigned_i;
      store_data_o  <= store_data_i;
    end
  end

endmodule

/* exu_bju.sv */
`timescale 1ns/1ns

module exu_bju import exu_pkg::*; (
  input  bjp_op_e         bjp_op_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] jp_base_i,
  input  logic [XLEN-1:0] jp_offset_i,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic [XLEN:0]   diff;
  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_ltu;
  logic [XLEN-1:0] target_sum;

  // one subtractor feeds all three compare flags
  assign diff = {1'b0, op1_i} + {1'b0, ~op2_i} + {{XLEN{1'b0}}, 1'b1};

  assign cmp_eq  = ~|diff[XLEN-1:0];
  assign cmp_ltu = ~diff[XLEN];
  assign cmp_lt  = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                   (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & diff[XLEN-1]);

  always_comb begin
    case (bjp_op_i)
      BJP_JAL:  taken_o = 1'b1;
      BJP_JALR: taken_o = 1'b1;
      BJP_BEQ:  taken_o = cmp_eq;
      BJP_BNE:  taken_o = ~cmp_eq;
      BJP_BLT:  taken_o = cmp_lt;
      BJP_BGE:  taken_o = ~cmp_lt;
      BJP_BLTU: taken_o = cmp_ltu;
      BJP_BGEU: taken_o = ~cmp_ltu;
      default:  taken_o = 1'b0;
    endcase
  end

  // base holds the pc or a register value as the decoder chose
  assign target_sum = jp_base_i + jp_offset_i;

  // jalr drops the lowest target bit
  assign target_o = (bjp_op_i == BJP_JALR) ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

endmodule

/* exu_alu.sv */
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
  input  alu_op_e         alu_op_i,
  input  logic            word_op_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  output logic [XLEN-1:0] alu_res_o
);

  logic            sub_mode;
  logic [XLEN-1:0] adder_in2;
  logic [XLEN-1:0] adder_sum;
  logic            adder_cout;
  logic            slt_flag;
  logic            sltu_flag;
  logic [5:0]      shamt;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [31:0]     sllw_res;
  logic [31:0]     srlw_res;
  logic [31:0]     sraw_res;
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] pre_res;
  logic            word_ext;

  // sub, slt and sltu run the shared adder as a subtractor
  assign sub_mode = (alu_op_i == ALU_SUB) || (alu_op_i == ALU_SLT) ||
                    (alu_op_i == ALU_SLTU);

  assign adder_in2 = sub_mode ? ~op2_i : op2_i;

  assign {adder_cout, adder_sum} = {1'b0, op1_i} + {1'b0, adder_in2} +
                                   {{XLEN{1'b0}}, sub_mode};

  // differing signs decide signed less, else the sign of the difference does
  assign slt_flag = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                    (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & adder_sum[XLEN-1]);

  // no carry out of op1 + ~op2 + 1 means a borrow
  assign sltu_flag = ~adder_cout;

  assign shamt = op2_i[5:0];

  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;
  assign sra_res = $signed(op1_i) >>> shamt;

  // word shifts only see the low half and a 5 bit amount
  assign sllw_res = op1_i[31:0] << shamt[4:0];
  assign srlw_res = op1_i[31:0] >> shamt[4:0];
  assign sraw_res = $signed(op1_i[31:0]) >>> shamt[4:0];

  // low 64 bits of the product
  assign mul_res = op1_i * op2_i;

  always_comb begin
    pre_res  = '0;
    word_ext = 1'b0;
    case (alu_op_i)
      ALU_ADD, ALU_SUB: begin
        pre_res  = adder_sum;
        word_ext = word_op_i;
      end
      ALU_SLL: begin
        pre_res  = word_op_i ? {32'b0, sllw_res} : sll_res;
        word_ext = word_op_i;
      end
      ALU_SRL: begin
        pre_res  = word_op_i ? {32'b0, srlw_res} : srl_res;
        word_ext = word_op_i;
      end
      ALU_SRA: begin
        pre_res  = word_op_i ? {32'b0, sraw_res} : sra_res;
        word_ext = word_op_i;
      end
      ALU_SLT:  pre_res = {{(XLEN-1){1'b0}}, slt_flag};
      ALU_SLTU: pre_res = {{(XLEN-1){1'b0}}, sltu_flag};
      ALU_XOR:  pre_res = op1_i ^ op2_i;
      ALU_OR:   pre_res = op1_i | op2_i;
      ALU_AND:  pre_res = op1_i & op2_i;
      // immediate already shifted into place by the decoder
      ALU_LUI:  pre_res = op2_i;
      ALU_MUL:  pre_res = mul_res;
      default:  pre_res = '0;
    endcase
  end

  // word forms sign extend from bit 31
  assign alu_res_o = word_ext ? {{(XLEN-32){pre_res[31]}}, pre_res[31:0]} : pre_res;

endmodule

/* exu_pkg.sv */
package exu_pkg;

  // register width of the rv64 core
  localparam int XLEN = 64;

  // destination register index width
  localparam int REG_IDX_W = 5;

  // instruction class as handed over by the decoder
  typedef enum logic [1:0] {
    CLS_ALU = 2'd0,
    CLS_BJP = 2'd1,
    CLS_LS  = 2'd2
  } op_class_e;

  // integer datapath operations
  // word forms are selected separately by word_op
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10,
    ALU_MUL  = 4'd11
  } alu_op_e;

  // branch and jump operations
  typedef enum logic [2:0] {
    BJP_JAL  = 3'd0,
    BJP_JALR = 3'd1,
    BJP_BEQ  = 3'd2,
    BJP_BNE  = 3'd3,
    BJP_BLT  = 3'd4,
    BJP_BGE  = 3'd5,
    BJP_BLTU = 3'd6,
    BJP_BGEU = 3'd7
  } bjp_op_e;

  // memory access size
  typedef enum logic [1:0] {
    LS_BYTE  = 2'd0,
    LS_HALF  = 2'd1,
    LS_WORD  = 2'd2,
    LS_DWORD = 2'd3
  } ls_size_e;

endpackage
